/* gb_video_pkg.sv */
`default_nettype none

package gb_video_pkg;

	// kept small so a frame simulates quickly
	localparam int SCREEN_W = 32;
	localparam int SCREEN_H = 16;

	localparam logic [12:0] TILE_MAP_BASE = 13'h1800;

	localparam logic [15:0] VRAM_BASE = 16'h8000;
	localparam logic [15:0] VRAM_END  = 16'h9fff;
	localparam logic [15:0] OAM_BASE  = 16'hfe00;
	localparam logic [15:0] OAM_END   = 16'hfe9f;
	localparam logic [15:0] IO_BASE   = 16'hff40; // 16 registers, up to 0xff4f

	localparam int VRAM_AW = 13;
	localparam int OAM_AW  = 8;

	localparam logic [3:0] REG_LCDC = 4'h0;
	localparam logic [3:0] REG_SCY  = 4'h2;
	localparam logic [3:0] REG_LY   = 4'h4;
	localparam logic [3:0] REG_BGP  = 4'h7;

	localparam int FIFO_DEPTH = 16;

	localparam logic [7:0] LCD_CMD_FRAME = 8'hb0;
	localparam int         LCD_WR_GAP    = 2; // at most 15, the gap counter is 4 bits

	typedef struct packed {
		logic [15:0] adr;
		logic [7:0]  wdata;
		logic        rd;
		logic        wr;
	} gb_bus_req_t;

	typedef struct packed {
		logic [12:0] adr;
		logic [7:0]  wdata;
		logic        rd;
		logic        wr;
	} vram_port_t;

	typedef struct packed {
		logic [1:0] shade;
		logic       line_end;
		logic       frame_end;
	} px_t;

	typedef struct packed {
		logic [7:0] data;
		logic       wr;
		logic       cd;  // low for commands, high for pixel data
		logic       cs;
		logic       vled;
	} lcd_bus_t;

endpackage

`default_nettype wire

/* gb_video_ram.sv */
`timescale 1ns/1ns
`default_nettype none

module gb_video_ram #(
	parameter int AW = 13
) (
	input  wire                     gbclk,
	input  wire gb_video_pkg::vram_port_t port,
	output logic [7:0]              rdata
);

	logic [7:0] mem [0:(1 << AW) - 1];
	logic [AW-1:0] adr;

	assign adr = port.adr[AW-1:0]; // upper bits fall away for the small OAM

	always_ff @(posedge gbclk) begin
		if (port.wr)
			mem[adr] <= port.wdata;
		if (port.rd)
			rdata <= mem[adr]; // holds the last read between accesses
	end

endmodule

`default_nettype wire

/* gb_bus_ctrl.sv */
`timescale 1ns/1ns
`default_nettype none

module gb_bus_ctrl (
	input  wire                         gbclk,
	input  wire                         reset,
	input  wire gb_video_pkg::gb_bus_req_t bus_req,
	output logic [7:0]                  rdata,
	input  wire gb_video_pkg::vram_port_t  ppu_port,
	input  wire                         need_vram,
	output logic [7:0]                  vram_rdata,
	output logic                        reg_rd,
	output logic                        reg_wr,
	output logic [3:0]                  reg_adr,
	output logic [7:0]                  reg_din,
	input  wire [7:0]                   reg_dout
);

	typedef enum logic [1:0] {SRC_NONE, SRC_VRAM, SRC_OAM, SRC_IO} src_t;

	logic in_vram, in_oam, in_io;
	gb_video_pkg::vram_port_t vram_port, oam_port;
	logic [7:0] oam_rdata;
	logic [7:0] io_q, held;
	logic       rd_pend;
	src_t       rd_src;

	assign in_vram = bus_req.adr >= gb_video_pkg::VRAM_BASE && bus_req.adr <= gb_video_pkg::VRAM_END;
	assign in_oam  = bus_req.adr >= gb_video_pkg::OAM_BASE && bus_req.adr <= gb_video_pkg::OAM_END;
	assign in_io   = (bus_req.adr & 16'hfff0) == gb_video_pkg::IO_BASE;

	assign reg_rd  = bus_req.rd && in_io;
	assign reg_wr  = bus_req.wr && in_io;
	assign reg_adr = bus_req.adr[3:0];
	assign reg_din = bus_req.wdata;

	always_comb begin
		if (need_vram) begin
			vram_port = ppu_port; // the picture processor wins, bus accesses are lost
		end else begin
			vram_port.adr   = bus_req.adr[12:0];
			vram_port.wdata = bus_req.wdata;
			vram_port.rd    = bus_req.rd && in_vram;
			vram_port.wr    = bus_req.wr && in_vram;
		end
	end

	always_comb begin
		oam_port.adr   = bus_req.adr[12:0];
		oam_port.wdata = bus_req.wdata;
		oam_port.rd    = bus_req.rd && in_oam;
		oam_port.wr    = bus_req.wr && in_oam;
	end

	always_ff @(posedge gbclk) begin
		if (reset) begin
			rd_pend <= 1'b0;
			rd_src  <= SRC_NONE;
		end else begin
			rd_pend <= bus_req.rd;
			if (bus_req.rd) begin
				if (in_io)
					rd_src <= SRC_IO;
				else if (in_vram && !need_vram)
					rd_src <= SRC_VRAM;
				else if (in_oam)
					rd_src <= SRC_OAM;
				else
					rd_src <= SRC_NONE;
			end
		end
	end

	always_ff @(posedge gbclk) begin
		if (reg_rd)
			io_q <= reg_dout;
		if (rd_pend)
			held <= rdata; // memory outputs may change later, keep the bus value
	end

	always_comb begin
		rdata = held;
		if (rd_pend) begin
			case (rd_src)
			SRC_VRAM: rdata = vram_rdata;
			SRC_OAM:  rdata = oam_rdata;
			SRC_IO:   rdata = io_q;
			default:  rdata = 8'hff;
			endcase
		end
	end

	gb_video_ram #(.AW(gb_video_pkg::VRAM_AW)) u_vram (
		.gbclk(gbclk),
		.port(vram_port),
		.rdata(vram_rdata)
	);

	gb_video_ram #(.AW(gb_video_pkg::OAM_AW)) u_oam (
		.gbclk(gbclk),
		.port(oam_port),
		.rdata(oam_rdata)
	);

endmodule

`default_nettype wire

/* lr35902_ppu.sv */
`timescale 1ns/1ns
`default_nettype none

module lr35902_ppu (
	input  wire                        gbclk,
	input  wire                        reset,
	input  wire                        reg_rd,
	input  wire                        reg_wr,
	input  wire [3:0]                  reg_adr,
	input  wire [7:0]                  reg_din,
	output logic [7:0]                 reg_dout,
	output gb_video_pkg::vram_port_t   vram_port,
	input  wire [7:0]                  vram_rdata,
	output logic                       need_vram,
	output gb_video_pkg::px_t          px,
	output logic                       push,
	input  wire                        full,
	output logic                       irq_vblank,
	output logic                       disp_on
);

	typedef enum logic [2:0] {S_IDLE, S_MAP, S_LO, S_HI, S_PUSH} state_t;

	state_t     state;
	logic       phase;     // second cycle of a VRAM read
	logic [7:0] lcdc, scy, bgp, ly;
	logic [7:0] scy_frame, bgp_frame;
	logic [4:0] col;
	logic [2:0] pix;
	logic [7:0] tile, plane_lo, plane_hi;
	logic [7:0] vline;
	logic [2:0] bit_sel;
	logic [1:0] idx;
	logic [12:0] map_adr, tile_adr;

	assign disp_on   = lcdc[7];
	assign need_vram = state != S_IDLE;

	assign vline    = ly + scy_frame; // wraps modulo 256
	assign map_adr  = gb_video_pkg::TILE_MAP_BASE + {3'b000, vline[7:3], col};
	assign tile_adr = {1'b0, tile, vline[2:0], 1'b0};

	always_comb begin
		vram_port.wdata = 8'h00;
		vram_port.wr    = 1'b0;
		vram_port.rd    = !phase && (state == S_MAP || state == S_LO || state == S_HI);
		case (state)
		S_MAP:   vram_port.adr = map_adr;
		S_HI:    vram_port.adr = tile_adr | 13'd1;
		default: vram_port.adr = tile_adr;
		endcase
	end

	assign bit_sel = 3'd7 - pix;
	assign idx     = {plane_hi[bit_sel], plane_lo[bit_sel]};

	always_comb begin
		px.shade     = bgp_frame[{idx, 1'b0} +: 2];
		px.line_end  = pix == 3'd7 && col == 5'(gb_video_pkg::SCREEN_W / 8 - 1);
		px.frame_end = px.line_end && ly == 8'(gb_video_pkg::SCREEN_H - 1);
	end

	assign push       = state == S_PUSH && !full;
	assign irq_vblank = push && px.frame_end;

	always_comb begin
		reg_dout = 8'hff;
		if (reg_rd) begin
			case (reg_adr)
			gb_video_pkg::REG_LCDC: reg_dout = lcdc;
			gb_video_pkg::REG_SCY:  reg_dout = scy;
			gb_video_pkg::REG_LY:   reg_dout = lcdc[7] ? ly : 8'h00;
			gb_video_pkg::REG_BGP:  reg_dout = bgp;
			default:                reg_dout = 8'hff;
			endcase
		end
	end

	always_ff @(posedge gbclk) begin
		if (reset) begin
			lcdc <= 8'h00;
			scy  <= 8'h00;
			bgp  <= 8'h00;
		end else if (reg_wr) begin
			case (reg_adr)
			gb_video_pkg::REG_LCDC: lcdc <= reg_din;
			gb_video_pkg::REG_SCY:  scy  <= reg_din;
			gb_video_pkg::REG_BGP:  bgp  <= reg_din;
			default: ;
			endcase
		end
	end

	// a started frame always runs to its end so the panel sees whole frames
	always_ff @(posedge gbclk) begin
		if (reset) begin
			state <= S_IDLE;
			phase <= 1'b0;
			ly    <= 8'h00;
			col   <= 5'd0;
			pix   <= 3'd0;
		end else begin
			case (state)
			S_IDLE: begin
				if (lcdc[7]) begin
					state <= S_MAP;
					ly    <= 8'h00;
					col   <= 5'd0;
					pix   <= 3'd0;
				end
			end
			S_MAP, S_LO, S_HI: begin
				phase <= !phase;
				if (phase) begin
					case (state)
					S_MAP:   state <= S_LO;
					S_LO:    state <= S_HI;
					default: state <= S_PUSH;
					endcase
				end
			end
			S_PUSH: begin
				if (!full) begin
					pix <= pix + 3'd1;
					if (pix == 3'd7) begin
						state <= S_MAP;
						col   <= px.line_end ? 5'd0 : col + 5'd1;
						if (px.frame_end) begin
							state <= S_IDLE;
							ly    <= 8'h00;
						end else if (px.line_end) begin
							ly <= ly + 8'h01;
						end
					end
				end
			end
			default: state <= S_IDLE;
			endcase
		end
	end

	always_ff @(posedge gbclk) begin
		if (state == S_IDLE && lcdc[7]) begin
			scy_frame <= scy; // mid-frame writes wait for the next frame
			bgp_frame <= bgp;
		end
		if (phase) begin
			case (state)
			S_MAP:   tile     <= vram_rdata;
			S_LO:    plane_lo <= vram_rdata;
			S_HI:    plane_hi <= vram_rdata;
			default: ;
			endcase
		end
	end

endmodule

`default_nettype wire

/* gb_pixel_fifo.sv */
`timescale 1ns/1ns
`default_nettype none

module gb_pixel_fifo #(
	parameter type T = logic [7:0]
) (
	input  wire   gbclk,
	input  wire   reset,
	input  wire   push,
	input  wire T din,
	output logic  full,
	input  wire   pop,
	output T      dout,
	output logic  empty
);

	T mem [0:gb_video_pkg::FIFO_DEPTH - 1];

	// depth is a power of two, so the pointers wrap by themselves
	logic [$clog2(gb_video_pkg::FIFO_DEPTH)-1:0] wptr, rptr;
	logic [$clog2(gb_video_pkg::FIFO_DEPTH):0]   count;
	logic wr_en, rd_en;

	assign full  = count == ($clog2(gb_video_pkg::FIFO_DEPTH) + 1)'(gb_video_pkg::FIFO_DEPTH);
	assign empty = count == '0;
	assign dout  = mem[rptr]; // head is visible before the pop

	assign wr_en = push && !full;
	assign rd_en = pop && !empty;

	always_ff @(posedge gbclk) begin
		if (wr_en)
			mem[wptr] <= din;
	end

	always_ff @(posedge gbclk) begin
		if (reset) begin
			wptr  <= '0;
			rptr  <= '0;
			count <= '0;
		end else begin
			if (wr_en)
				wptr <= wptr + 1'b1;
			if (rd_en)
				rptr <= rptr + 1'b1;
			if (wr_en && !rd_en)
				count <= count + 1'b1;
			else if (rd_en && !wr_en)
				count <= count - 1'b1;
		end
	end

endmodule

`default_nettype wire

/* uc1611.sv */
`timescale 1ns/1ns
`default_nettype none

module uc1611 (
	input  wire                    gbclk,
	input  wire                    reset,
	input  wire                    disp_on,
	input  wire gb_video_pkg::px_t px,
	input  wire                    empty,
	output logic                   pop,
	output gb_video_pkg::lcd_bus_t lcd
);

	typedef enum logic [1:0] {S_IDLE, S_FILL, S_SEND, S_END} state_t;

	state_t     state;
	logic [7:0] shift;
	logic [1:0] n_px;
	logic       is_cmd;
	logic       last;   // byte holds the frame_end pixel
	logic [3:0] gap;

	assign pop = state == S_FILL && !empty;

	always_ff @(posedge gbclk) begin
		if (pop)
			shift <= {shift[5:0], px.shade}; // first pixel ends up in bits 7-6
	end

	always_ff @(posedge gbclk) begin
		if (reset) begin
			state    <= S_IDLE;
			n_px     <= 2'd0;
			is_cmd   <= 1'b0;
			last     <= 1'b0;
			gap      <= 4'(gb_video_pkg::LCD_WR_GAP);
			lcd.wr   <= 1'b0;
			lcd.cd   <= 1'b0;
			lcd.cs   <= 1'b0;
			lcd.vled <= 1'b0;
		end else begin
			lcd.vled <= disp_on;
			lcd.wr   <= 1'b0;
			if (lcd.wr)
				gap <= 4'd0;
			else if (gap != 4'hf)
				gap <= gap + 4'd1;

			case (state)
			S_IDLE: begin
				if (!empty) begin
					state  <= S_SEND; // pixels waiting mean a new frame has begun
					is_cmd <= 1'b1;
					last   <= 1'b0;
					n_px   <= 2'd0;
					lcd.cs <= 1'b1;
				end
			end
			S_FILL: begin
				if (pop) begin
					n_px <= n_px + 2'd1;
					if (n_px == 2'd3) begin
						state <= S_SEND;
						last  <= px.frame_end;
					end
				end
			end
			S_SEND: begin
				if (!lcd.wr && gap >= 4'(gb_video_pkg::LCD_WR_GAP)) begin
					lcd.wr   <= 1'b1;
					lcd.data <= is_cmd ? gb_video_pkg::LCD_CMD_FRAME : shift;
					lcd.cd   <= !is_cmd;
					is_cmd   <= 1'b0;
					state    <= last ? S_END : S_FILL;
				end
			end
			default: begin
				lcd.cs <= 1'b0;
				state  <= S_IDLE;
			end
			endcase
		end
	end

endmodule

`default_nettype wire

/* gb_video_top.sv */
`timescale 1ns/1ns
`default_nettype none

module gb_video_top (
	input  wire                            gbclk,
	input  wire                            reset,
	input  wire gb_video_pkg::gb_bus_req_t bus_req,
	output wire [7:0]                      rdata,
	output wire                            irq_vblank,
	output wire gb_video_pkg::lcd_bus_t    lcd
);

	wire gb_video_pkg::vram_port_t ppu_port;
	wire gb_video_pkg::px_t        ppu_px;
	wire gb_video_pkg::px_t        fifo_px;
	wire       need_vram;
	wire [7:0] vram_rdata;
	wire       reg_rd;
	wire       reg_wr;
	wire [3:0] reg_adr;
	wire [7:0] reg_din;
	wire [7:0] reg_dout;
	wire       push;
	wire       full;
	wire       pop;
	wire       empty;
	wire       disp_on;

	gb_bus_ctrl u_bus (
		.gbclk(gbclk),
		.reset(reset),
		.bus_req(bus_req),
		.rdata(rdata),
		.ppu_port(ppu_port),
		.need_vram(need_vram),
		.vram_rdata(vram_rdata),
		.reg_rd(reg_rd),
		.reg_wr(reg_wr),
		.reg_adr(reg_adr),
		.reg_din(reg_din),
		.reg_dout(reg_dout)
	);

	lr35902_ppu u_ppu (
		.gbclk(gbclk),
		.reset(reset),
		.reg_rd(reg_rd),
		.reg_wr(reg_wr),
		.reg_adr(reg_adr),
		.reg_din(reg_din),
		.reg_dout(reg_dout),
		.vram_port(ppu_port),
		.vram_rdata(vram_rdata),
		.need_vram(need_vram),
		.px(ppu_px),
		.push(push),
		.full(full),
		.irq_vblank(irq_vblank),
		.disp_on(disp_on)
	);

	gb_pixel_fifo #(.T(gb_video_pkg::px_t)) u_fifo (
		.gbclk(gbclk),
		.reset(reset),
		.push(push),
		.din(ppu_px),
		.full(full),
		.pop(pop),
		.dout(fifo_px),
		.empty(empty)
	);

	uc1611 u_lcd (
		.gbclk(gbclk),
		.reset(reset),
		.disp_on(disp_on),
		.px(fifo_px),
		.empty(empty),
		.pop(pop),
		.lcd(lcd)
	);

endmodule

`default_nettype wire

/* gb_video_asserts.sv */
`timescale 1ns/1ns
`default_nettype none

module gb_video_asserts (
	input wire                            gbclk,
	input wire                            reset,
	input wire gb_video_pkg::gb_bus_req_t bus_req,
	input wire gb_video_pkg::lcd_bus_t    lcd,
	input wire                            full,
	input wire [2:0]                      fetch_pix,
	input wire                            irq_vblank
);

	logic [7:0] wr_idle; // low cycles of lcd wr since its last pulse

	always_ff @(posedge gbclk) begin
		if (reset)
			wr_idle <= 8'hff;
		else if (lcd.wr)
			wr_idle <= 8'h00;
		else if (wr_idle != 8'hff)
			wr_idle <= wr_idle + 8'h01;
	end

	a_bus_strobes: assert property (@(posedge gbclk) disable iff (reset)
		!(bus_req.rd && bus_req.wr))
		else $error("bus rd and wr strobes high in the same cycle");

	a_lcd_wr_gap: assert property (@(posedge gbclk) disable iff (reset)
		lcd.wr |-> wr_idle >= 8'(gb_video_pkg::LCD_WR_GAP))
		else $error("lcd wr pulses closer than the minimum gap");

	a_fetch_stall: assert property (@(posedge gbclk) disable iff (reset)
		full |=> $stable(fetch_pix))
		else $error("pixel fetcher advanced while the FIFO was full");

	a_irq_pulse: assert property (@(posedge gbclk) disable iff (reset)
		irq_vblank |=> !irq_vblank)
		else $error("irq_vblank longer than one cycle");

endmodule

bind gb_video_top gb_video_asserts u_asserts (
	.gbclk(gbclk),
	.reset(reset),
	.bus_req(bus_req),
	.lcd(lcd),
	.full(full),
	.fetch_pix(u_ppu.pix),
	.irq_vblank(irq_vblank)
);

`default_nettype wire

/* tb_gb_video.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_gb_video;

	logic gbclk;
	logic reset;
	gb_video_pkg::gb_bus_req_t bus_req;
	wire [7:0] rdata;
	wire irq_vblank;
	wire gb_video_pkg::lcd_bus_t lcd;

	logic [7:0] vram_mirror [0:8191];
	logic [7:0] oam_mirror [0:159];
	logic [7:0] frame_scy [0:1];
	logic [7:0] frame_bgp [0:1];
	logic [31:0] seed = 32'h3d44ed9a;
	logic [9:0] cap_q [$]; // cs, cd, data of each lcd write
	int cap_total = 0;
	int irq_count = 0;
	int n_checked = 0;
	int err_bus = 0;
	int err_lcd = 0;
	int err_flow = 0;

	gb_video_top u_dut (
		.gbclk(gbclk),
		.reset(reset),
		.bus_req(bus_req),
		.rdata(rdata),
		.irq_vblank(irq_vblank),
		.lcd(lcd)
	);

	initial begin
		gbclk = 1'b0;
		forever #20 gbclk = ~gbclk;
	end

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	task automatic draw_byte(output logic [7:0] b);
		seed = lcg_next(seed);
		b = seed[23:16];
	endtask

	// expected panel byte at data position pos of a frame rendered with scy and bgp
	function automatic logic [7:0] lcd_ref_byte(input int pos, input logic [7:0] scy,
	                                             input logic [7:0] bgp);
		logic [7:0] acc;
		logic [7:0] line, tile, lo, hi;
		logic [1:0] idx;
		int i, p, x, y, adr;
		acc = 8'h00;
		for (i = 0; i < 4; i++) begin
			p = pos * 4 + i;
			x = p % gb_video_pkg::SCREEN_W;
			y = p / gb_video_pkg::SCREEN_W;
			line = y[7:0] + scy; // wraps like the hardware
			adr = int'(gb_video_pkg::TILE_MAP_BASE) + int'(line[7:3]) * 32 + x / 8;
			tile = vram_mirror[adr];
			adr = int'(tile) * 16 + int'(line[2:0]) * 2;
			lo = vram_mirror[adr];
			hi = vram_mirror[adr + 1];
			idx = {hi[7 - x % 8], lo[7 - x % 8]};
			acc = {acc[5:0], bgp[2 * idx +: 2]};
		end
		return acc;
	endfunction

	task automatic bus_write(input logic [15:0] adr, input logic [7:0] data);
		@(negedge gbclk);
		bus_req.adr = adr;
		bus_req.wdata = data;
		bus_req.wr = 1'b1;
		@(negedge gbclk);
		bus_req.wr = 1'b0;
	endtask

	task automatic bus_read(input logic [15:0] adr, output logic [7:0] data);
		@(negedge gbclk);
		bus_req.adr = adr;
		bus_req.rd = 1'b1;
		@(negedge gbclk);
		bus_req.rd = 1'b0;
		data = rdata; // the registered read data is valid one cycle after the strobe
	endtask

	task automatic read_expect(input string name, input logic [15:0] adr,
	                           input logic [7:0] exp);
		logic [7:0] got;
		bus_read(adr, got);
		if (got !== exp) begin
			$display("ERROR %s at %h: expected %h, actual %h", name, adr, exp, got);
			err_bus++;
		end
	endtask

	task automatic vram_store(input int offset, input logic [7:0] data);
		bus_write(16'h8000 + 16'(offset), data);
		vram_mirror[offset] = data;
	endtask

	always @(posedge gbclk) begin
		if (reset)
			irq_count <= 0;
		else if (irq_vblank)
			irq_count <= irq_count + 1;
	end

	always @(negedge gbclk) begin
		if (!reset && lcd.wr) begin
			cap_q.push_back({lcd.cs, lcd.cd, lcd.data});
			cap_total++;
		end
	end

	initial begin : compare
		logic [9:0] e;
		logic [7:0] exp;
		int f, k;
		for (f = 0; f < 2; f++) begin
			for (k = 0; k <= gb_video_pkg::SCREEN_W * gb_video_pkg::SCREEN_H / 4; k++) begin
				while (cap_q.size() == 0)
					@(posedge gbclk);
				e = cap_q.pop_front();
				if (k == 0)
					exp = gb_video_pkg::LCD_CMD_FRAME; // command byte leads every frame
				else
					exp = lcd_ref_byte(k - 1, frame_scy[f], frame_bgp[f]);
				if (e[8] !== (k != 0)) begin
					$display("ERROR lcd_cd frame %0d byte %0d: expected %b, actual %b",
					         f, k, k != 0, e[8]);
					err_lcd++;
				end
				if (e[9] !== 1'b1) begin
					$display("ERROR lcd_cs frame %0d byte %0d: expected 1, actual %b", f, k, e[9]);
					err_lcd++;
				end
				if (e[7:0] !== exp) begin
					$display("ERROR lcd_data frame %0d byte %0d: expected %h, actual %h",
					         f, k, exp, e[7:0]);
					err_lcd++;
				end
				n_checked++;
			end
		end
	end

	initial begin : watchdog
		int cycles;
		cycles = 2 * gb_video_pkg::SCREEN_W * gb_video_pkg::SCREEN_H * 8
		         + 8 * (128 + 512 + 160 + 16) + 1000;
		#(cycles * 40);
		$display("timeout: the run did not finish within %0d cycles", cycles);
		$display("*** FAILED ***");
		$finish;
	end

	initial begin : main
		logic [7:0] b;
		logic [7:0] keep;
		int i, r, c;
		bus_req = '0;
		reset = 1'b1;
		repeat (10) @(negedge gbclk);
		reset = 1'b0;
		if (irq_vblank !== 1'b0 || lcd.wr !== 1'b0 || lcd.cs !== 1'b0 || lcd.vled !== 1'b0) begin
			$display("irq or panel outputs are not idle after reset");
			err_flow++;
		end

		bus_write(16'hff40, 8'h11);
		read_expect("lcdc", 16'hff40, 8'h11);
		bus_write(16'hff42, 8'h5a);
		read_expect("scy", 16'hff42, 8'h5a);
		bus_write(16'hff47, 8'he4);
		read_expect("bgp", 16'hff47, 8'he4);
		read_expect("ly_off", 16'hff44, 8'h00);
		read_expect("unmapped", 16'h1234, 8'hff);
		read_expect("unmapped", 16'hc000, 8'hff);
		read_expect("unmapped", 16'hfea0, 8'hff);

		// only tiles 0..31 are referenced, so only their data is filled
		for (r = 0; r < 32; r++) begin
			for (c = 0; c < 4; c++) begin
				draw_byte(b);
				vram_store(int'(gb_video_pkg::TILE_MAP_BASE) + r * 32 + c, b & 8'h1f);
			end
		end
		for (i = 0; i < 512; i++) begin
			draw_byte(b);
			vram_store(i, b);
		end
		draw_byte(keep);
		keep = keep & 8'h7f; // a value below 0x80 cannot be taken for a blocked read
		vram_store(16'h1f00, keep);
		for (i = 0; i < 160; i++) begin
			draw_byte(b);
			oam_mirror[i] = b;
			bus_write(16'hfe00 + 16'(i), b);
		end
		for (r = 0; r < 32; r++) begin
			for (c = 0; c < 4; c++) begin
				i = int'(gb_video_pkg::TILE_MAP_BASE) + r * 32 + c;
				read_expect("vram_map", 16'h8000 + 16'(i), vram_mirror[i]);
			end
		end
		for (i = 0; i < 512; i++)
			read_expect("vram_tile", 16'h8000 + 16'(i), vram_mirror[i]);
		read_expect("vram_spare", 16'h9f00, keep);
		for (i = 0; i < 160; i++)
			read_expect("oam", 16'hfe00 + 16'(i), oam_mirror[i]);

		frame_scy[0] = 8'h5a;
		frame_bgp[0] = 8'he4;
		frame_scy[1] = 8'h13;
		frame_bgp[1] = 8'h1b;
		bus_write(16'hff40, 8'h91);
		read_expect("vram_busy_read", 16'h9f00, 8'hff);
		bus_write(16'h9f00, ~keep); // must be dropped while the fetcher owns VRAM
		bus_write(16'hff42, frame_scy[1]);
		bus_write(16'hff47, frame_bgp[1]);
		if (irq_count != 0) begin
			$display("first frame ended before the busy window accesses were done");
			err_flow++;
		end
		if (lcd.vled !== 1'b1) begin
			$display("ERROR lcd_vled_on: expected 1, actual %b", lcd.vled);
			err_flow++;
		end

		while (irq_count < 1)
			@(negedge gbclk);
		bus_write(16'hff40, 8'h11); // second frame already started and runs to its end
		while (irq_count < 2)
			@(negedge gbclk);
		while (n_checked < 2 * (gb_video_pkg::SCREEN_W * gb_video_pkg::SCREEN_H / 4 + 1))
			@(negedge gbclk);
		repeat (100) @(negedge gbclk);

		if (irq_count != 2) begin
			$display("ERROR irq_count: expected 2, actual %0d", irq_count);
			err_flow++;
		end
		if (cap_total != 2 * (gb_video_pkg::SCREEN_W * gb_video_pkg::SCREEN_H / 4 + 1)) begin
			$display("ERROR lcd_writes: expected %0d, actual %0d",
			         2 * (gb_video_pkg::SCREEN_W * gb_video_pkg::SCREEN_H / 4 + 1), cap_total);
			err_flow++;
		end
		if (lcd.vled !== 1'b0 || lcd.cs !== 1'b0) begin
			$display("ERROR lcd_idle_off: expected vled 0 cs 0, actual vled %b cs %b",
			         lcd.vled, lcd.cs);
			err_flow++;
		end
		read_expect("vram_dropped_write", 16'h9f00, keep);
		read_expect("ly_after_off", 16'hff44, 8'h00);

		$display("errors: bus %0d, lcd %0d, flow %0d, lcd bytes checked %0d",
		         err_bus, err_lcd, err_flow, n_checked);
		if (err_bus + err_lcd + err_flow == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

endmodule

`default_nettype wire

/* flist.f */
gb_video_pkg.sv
gb_video_ram.sv
gb_bus_ctrl.sv
lr35902_ppu.sv
gb_pixel_fifo.sv
uc1611.sv
gb_video_top.sv
gb_video_asserts.sv
tb_gb_video.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/1ns -Wno-fatal
TOP       = tb_gb_video
FLIST     = flist.f
OBJ_DIR   = obj_dir
BIN       = $(OBJ_DIR)/V$(TOP)
SRCS      = $(wildcard *.sv)
LOG       = sim.log
PASS_MSG  = *** PASSED ***

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -qF '$(PASS_MSG)' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
